// ==== padframe_pkg.sv ====
/*
 * padframe shared definitions
 * pad select codes, register map and the configuration word layout
 */

`default_nettype none

package padframe_pkg;

  localparam int unsigned CfgAddrWidth = 2;
  localparam int unsigned CfgDataWidth = 16;
  localparam int unsigned PadSelWidth  = 2;
  localparam int unsigned MaxMuxPads   = 8;

  // pad function codes
  typedef enum logic [PadSelWidth-1:0] {
    PAD_SEL_GPIO    = 2'd0,
    PAD_SEL_UART_TX = 2'd1,
    PAD_SEL_SPI_SCK = 2'd2,
    PAD_SEL_OFF     = 2'd3
  } pad_sel_e;

  ////////////////////
  // register map
  ////////////////////

  localparam logic [CfgAddrWidth-1:0] CfgAddrMuxSel = 2'd0;
  localparam logic [CfgAddrWidth-1:0] CfgAddrInMask = 2'd1;
  // addresses 2 and 3 unmapped

  // one config word, seen as pad selects or as the input-force mask
  typedef union packed {
    pad_sel_e [MaxMuxPads-1:0] sel;
    struct packed {
      logic [CfgDataWidth-MaxMuxPads-1:0] reserved;
      logic [MaxMuxPads-1:0]              force_in;
    } mask;
  } pad_cfg_word_u;

endpackage

`default_nettype wire

// ==== padframe_cfg_cdc.sv ====
/*
 * padframe config receiver
 * four-phase req/ack link into the reference clock domain,
 * one register access per handshake
 */

`timescale 1ns/10ps
`default_nettype none

module padframe_cfg_cdc (
  input  logic                                  ref_clk_i,
  input  logic                                  rst_n_i,
  // async four-phase side
  input  logic                                  cfg_req_i,
  input  logic [padframe_pkg::CfgAddrWidth-1:0] cfg_addr_i,
  input  logic                                  cfg_we_i,
  input  logic [padframe_pkg::CfgDataWidth-1:0] cfg_wdata_i,
  output logic                                  cfg_ack_o,
  output logic [padframe_pkg::CfgDataWidth-1:0] cfg_rdata_o,
  output logic                                  cfg_err_o,
  // register access side
  output logic                                  acc_valid_o,
  output logic [padframe_pkg::CfgAddrWidth-1:0] acc_addr_o,
  output logic                                  acc_we_o,
  output logic [padframe_pkg::CfgDataWidth-1:0] acc_wdata_o,
  input  logic [padframe_pkg::CfgDataWidth-1:0] acc_rdata_i,
  input  logic                                  acc_err_i
);

  localparam logic StIdle  = 1'b0;
  localparam logic StAcked = 1'b1;

  logic [1:0] req_sync_q;
  logic       req_sync;
  logic       state_q;
  logic       state_d;

  ////////////////////
  // req synchronizer
  ////////////////////

  always_ff @(posedge ref_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      req_sync_q <= 2'b00;
    end else begin
      req_sync_q <= {req_sync_q[0], cfg_req_i};
    end
  end

  assign req_sync = req_sync_q[1];

  ////////////////////
  // ack FSM
  ////////////////////

  always_comb begin
    state_d     = state_q;
    acc_valid_o = 1'b0;
    case (state_q)
      StIdle: begin
        if (req_sync) begin
          // single access on first sight of req
          acc_valid_o = 1'b1;
          state_d     = StAcked;
        end
      end
      default: begin
        if (!req_sync) begin
          state_d = StIdle;
        end
      end
    endcase
  end

  always_ff @(posedge ref_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= StIdle;
    end else begin
      state_q <= state_d;
    end
  end

  assign cfg_ack_o = (state_q == StAcked);

  // bundled data stays stable from before req until ack
  assign acc_addr_o  = cfg_addr_i;
  assign acc_we_o    = cfg_we_i;
  assign acc_wdata_o = cfg_wdata_i;

  // response registers hold while ack is high
  always_ff @(posedge ref_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cfg_rdata_o <= '0;
      cfg_err_o   <= 1'b0;
    end else if (acc_valid_o) begin
      cfg_rdata_o <= acc_rdata_i;
      cfg_err_o   <= acc_err_i;
    end
  end

endmodule

`default_nettype wire

// ==== padframe_cfg_regs.sv ====
/*
 * padframe register file
 * pad select word and input-force mask, error on unmapped addresses
 */

`timescale 1ns/10ps
`default_nettype none

module padframe_cfg_regs #(
  parameter int unsigned NumMuxPads = 8
) (
  input  logic                                  ref_clk_i,
  input  logic                                  rst_n_i,
  input  logic                                  acc_valid_i,
  input  logic [padframe_pkg::CfgAddrWidth-1:0] acc_addr_i,
  input  logic                                  acc_we_i,
  input  logic [padframe_pkg::CfgDataWidth-1:0] acc_wdata_i,
  output logic [padframe_pkg::CfgDataWidth-1:0] acc_rdata_o,
  output logic                                  acc_err_o,
  output padframe_pkg::pad_cfg_word_u           pad_sel_o,
  output logic [NumMuxPads-1:0]                 in_mask_o
);

  import padframe_pkg::*;

  localparam int unsigned SelBits = NumMuxPads * PadSelWidth;
  // select fields of pads that exist
  localparam logic [CfgDataWidth-1:0] SelMask =
    {CfgDataWidth{1'b1}} >> (CfgDataWidth - SelBits);

  pad_cfg_word_u         sel_q;
  logic [NumMuxPads-1:0] mask_q;
  pad_cfg_word_u         wdata;
  pad_cfg_word_u         mask_rd;
  logic [CfgDataWidth-1:0] rd_value;

  assign wdata = acc_wdata_i;

  ////////////////////
  // read decode
  ////////////////////

  always_comb begin
    mask_rd               = '0;
    mask_rd.mask.force_in = MaxMuxPads'(mask_q);
    rd_value              = '0;
    acc_err_o             = 1'b0;
    case (acc_addr_i)
      CfgAddrMuxSel: rd_value = sel_q;
      CfgAddrInMask: rd_value = mask_rd;
      default:       acc_err_o = 1'b1;
    endcase
    // read data only on reads
    acc_rdata_o = acc_we_i ? '0 : rd_value;
  end

  ////////////////////
  // write
  ////////////////////

  always_ff @(posedge ref_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      // all present pads off
      sel_q  <= SelMask;
      mask_q <= '0;
    end else if (acc_valid_i && acc_we_i) begin
      case (acc_addr_i)
        CfgAddrMuxSel: sel_q  <= acc_wdata_i & SelMask;
        CfgAddrInMask: mask_q <= wdata.mask.force_in[NumMuxPads-1:0];
        default: ;
      endcase
    end
  end

  assign pad_sel_o = sel_q;
  assign in_mask_o = mask_q;

endmodule

`default_nettype wire

// ==== padframe_pad_mux.sv ====
/*
 * padframe pad mux
 * routes GPIO, UART TX and SPI clock onto the muxed pads,
 * pad inputs back to GPIO
 */

`timescale 1ns/10ps
`default_nettype none

module padframe_pad_mux #(
  parameter int unsigned NumMuxPads = 8
) (
  input  padframe_pkg::pad_cfg_word_u pad_sel_i,
  input  logic [NumMuxPads-1:0]       in_mask_i,
  input  logic [NumMuxPads-1:0]       gpio_out_i,
  input  logic [NumMuxPads-1:0]       gpio_oe_i,
  input  logic                        uart_tx_i,
  input  logic                        spi_sck_i,
  input  logic [NumMuxPads-1:0]       pad_in_i,
  output logic [NumMuxPads-1:0]       pad_out_o,
  output logic [NumMuxPads-1:0]       pad_oe_o,
  output logic [NumMuxPads-1:0]       gpio_in_o
);

  import padframe_pkg::*;

  logic [NumMuxPads-1:0] drive_en;

  always_comb begin
    pad_out_o = '0;
    drive_en  = '0;
    gpio_in_o = '0;
    for (int unsigned i = 0; i < NumMuxPads; i++) begin
      case (pad_sel_i.sel[i])
        PAD_SEL_GPIO: begin
          pad_out_o[i] = gpio_out_i[i];
          drive_en[i]  = gpio_oe_i[i];
          gpio_in_o[i] = pad_in_i[i];
        end
        PAD_SEL_UART_TX: begin
          pad_out_o[i] = uart_tx_i;
          drive_en[i]  = 1'b1;
        end
        PAD_SEL_SPI_SCK: begin
          pad_out_o[i] = spi_sck_i;
          drive_en[i]  = 1'b1;
        end
        // off, pad undriven
        default: ;
      endcase
    end
  end

  // force to input, output value left as is
  assign pad_oe_o = drive_en & ~in_mask_i;

endmodule

`default_nettype wire

// ==== padframe_top.sv ====
/*
 * padframe top
 * config receiver, register file and pad mux
 */

`timescale 1ns/10ps
`default_nettype none

module padframe_top #(
  parameter int unsigned NumMuxPads = 8
) (
  input  logic                                  ref_clk_i,
  input  logic                                  rst_n_i,
  // config link
  input  logic                                  cfg_req_i,
  input  logic [padframe_pkg::CfgAddrWidth-1:0] cfg_addr_i,
  input  logic                                  cfg_we_i,
  input  logic [padframe_pkg::CfgDataWidth-1:0] cfg_wdata_i,
  output logic                                  cfg_ack_o,
  output logic [padframe_pkg::CfgDataWidth-1:0] cfg_rdata_o,
  output logic                                  cfg_err_o,
  // peripherals and pads
  input  logic [NumMuxPads-1:0]                 gpio_out_i,
  input  logic [NumMuxPads-1:0]                 gpio_oe_i,
  input  logic                                  uart_tx_i,
  input  logic                                  spi_sck_i,
  input  logic [NumMuxPads-1:0]                 pad_in_i,
  output logic [NumMuxPads-1:0]                 pad_out_o,
  output logic [NumMuxPads-1:0]                 pad_oe_o,
  output logic [NumMuxPads-1:0]                 gpio_in_o
);

  import padframe_pkg::*;

  logic                    acc_valid;
  logic [CfgAddrWidth-1:0] acc_addr;
  logic                    acc_we;
  logic [CfgDataWidth-1:0] acc_wdata;
  logic [CfgDataWidth-1:0] acc_rdata;
  logic                    acc_err;
  pad_cfg_word_u           pad_sel;
  logic [NumMuxPads-1:0]   in_mask;

  padframe_cfg_cdc u_cfg_cdc (
    .ref_clk_i   ( ref_clk_i   ),
    .rst_n_i     ( rst_n_i     ),
    .cfg_req_i   ( cfg_req_i   ),
    .cfg_addr_i  ( cfg_addr_i  ),
    .cfg_we_i    ( cfg_we_i    ),
    .cfg_wdata_i ( cfg_wdata_i ),
    .cfg_ack_o   ( cfg_ack_o   ),
    .cfg_rdata_o ( cfg_rdata_o ),
    .cfg_err_o   ( cfg_err_o   ),
    .acc_valid_o ( acc_valid   ),
    .acc_addr_o  ( acc_addr    ),
    .acc_we_o    ( acc_we      ),
    .acc_wdata_o ( acc_wdata   ),
    .acc_rdata_i ( acc_rdata   ),
    .acc_err_i   ( acc_err     )
  );

  padframe_cfg_regs #(
    .NumMuxPads ( NumMuxPads )
  ) u_cfg_regs (
    .ref_clk_i   ( ref_clk_i ),
    .rst_n_i     ( rst_n_i   ),
    .acc_valid_i ( acc_valid ),
    .acc_addr_i  ( acc_addr  ),
    .acc_we_i    ( acc_we    ),
    .acc_wdata_i ( acc_wdata ),
    .acc_rdata_o ( acc_rdata ),
    .acc_err_o   ( acc_err   ),
    .pad_sel_o   ( pad_sel   ),
    .in_mask_o   ( in_mask   )
  );

  padframe_pad_mux #(
    .NumMuxPads ( NumMuxPads )
  ) u_pad_mux (
    .pad_sel_i  ( pad_sel    ),
    .in_mask_i  ( in_mask    ),
    .gpio_out_i ( gpio_out_i ),
    .gpio_oe_i  ( gpio_oe_i  ),
    .uart_tx_i  ( uart_tx_i  ),
    .spi_sck_i  ( spi_sck_i  ),
    .pad_in_i   ( pad_in_i   ),
    .pad_out_o  ( pad_out_o  ),
    .pad_oe_o   ( pad_oe_o   ),
    .gpio_in_o  ( gpio_in_o  )
  );

endmodule

`default_nettype wire

// ==== padframe_props.sv ====
/*
 * handshake properties of the padframe config receiver
 */

`timescale 1ns/10ps
`default_nettype none

module padframe_props (
  input logic ref_clk_i,
  input logic rst_n_i,
  input logic req_i,
  input logic ack_i,
  input logic acc_valid_i
);

  int unsigned fail_count = 0;
  logic        strobe_seen_q;

  // one strobe allowed per high phase of req
  always_ff @(posedge ref_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      strobe_seen_q <= 1'b0;
    end else if (!req_i) begin
      strobe_seen_q <= 1'b0;
    end else if (acc_valid_i) begin
      strobe_seen_q <= 1'b1;
    end
  end

  a_ack_rise: assert property (@(posedge ref_clk_i) disable iff (!rst_n_i)
    $rose(ack_i) |-> $past(req_i)) else begin
    fail_count++;
    $error("ack rose while req was low");
  end

  a_ack_fall: assert property (@(posedge ref_clk_i) disable iff (!rst_n_i)
    $fell(ack_i) |-> !$past(req_i)) else begin
    fail_count++;
    $error("ack fell while req was high");
  end

  a_strobe_width: assert property (@(posedge ref_clk_i) disable iff (!rst_n_i)
    acc_valid_i |=> !acc_valid_i) else begin
    fail_count++;
    $error("access strobe wider than one cycle");
  end

  a_one_strobe: assert property (@(posedge ref_clk_i) disable iff (!rst_n_i)
    acc_valid_i |-> !strobe_seen_q) else begin
    fail_count++;
    $error("second access strobe within one req phase");
  end

endmodule

bind padframe_cfg_cdc padframe_props u_props (
  .ref_clk_i   ( ref_clk_i   ),
  .rst_n_i     ( rst_n_i     ),
  .req_i       ( cfg_req_i   ),
  .ack_i       ( cfg_ack_o   ),
  .acc_valid_i ( acc_valid_o )
);

`default_nettype wire

// ==== tb_padframe_top.sv ====
/*
 * testbench for the padframe top
 * random config traffic over the four-phase link,
 * pad routing compared with a model of the select word and mask
 */

`timescale 1ns/10ps
`default_nettype none

module tb_padframe_top;

  import padframe_pkg::*;

  localparam int unsigned NumPads        = 8;
  localparam int unsigned ClkPeriod      = 8;
  localparam int unsigned NumRoundTrips  = 24;
  localparam int unsigned NumUnmapped    = 8;
  localparam int unsigned NumRouteRounds = 12;
  localparam int unsigned RouteCycles    = 16;
  localparam int unsigned AckTimeout     = 10;
  localparam int unsigned NumTxn = 2 * NumRoundTrips + 3 * NumUnmapped + 4 * NumRouteRounds + 2;
  localparam int unsigned MarginCycles = 2 * NumRouteRounds * (RouteCycles + 1) + 200;

  logic               ref_clk_i;
  logic               rst_n_i;
  logic               cfg_req_i;
  logic [1:0]         cfg_addr_i;
  logic               cfg_we_i;
  logic [15:0]        cfg_wdata_i;
  logic               cfg_ack_o;
  logic [15:0]        cfg_rdata_o;
  logic               cfg_err_o;
  logic [NumPads-1:0] gpio_out_i;
  logic [NumPads-1:0] gpio_oe_i;
  logic               uart_tx_i;
  logic               spi_sck_i;
  logic [NumPads-1:0] pad_in_i;
  logic [NumPads-1:0] pad_out_o;
  logic [NumPads-1:0] pad_oe_o;
  logic [NumPads-1:0] gpio_in_o;

  logic [31:0]        rng_state;
  // model of the register file
  logic [15:0]        sel_m;
  logic [NumPads-1:0] mask_m;

  padframe_top #(
    .NumMuxPads ( NumPads )
  ) dut (
    .ref_clk_i   ( ref_clk_i   ),
    .rst_n_i     ( rst_n_i     ),
    .cfg_req_i   ( cfg_req_i   ),
    .cfg_addr_i  ( cfg_addr_i  ),
    .cfg_we_i    ( cfg_we_i    ),
    .cfg_wdata_i ( cfg_wdata_i ),
    .cfg_ack_o   ( cfg_ack_o   ),
    .cfg_rdata_o ( cfg_rdata_o ),
    .cfg_err_o   ( cfg_err_o   ),
    .gpio_out_i  ( gpio_out_i  ),
    .gpio_oe_i   ( gpio_oe_i   ),
    .uart_tx_i   ( uart_tx_i   ),
    .spi_sck_i   ( spi_sck_i   ),
    .pad_in_i    ( pad_in_i    ),
    .pad_out_o   ( pad_out_o   ),
    .pad_oe_o    ( pad_oe_o    ),
    .gpio_in_o   ( gpio_in_o   )
  );

  always #(ClkPeriod / 2) ref_clk_i = ~ref_clk_i;

  task automatic stop_on_failure();
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic logic [31:0] rand_word();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  task automatic expect_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (exp === act) else begin
      $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
      stop_on_failure();
    end
  endtask

  task automatic drive_periph();
    logic [31:0] r;
    r          = rand_word();
    gpio_out_i = r[7:0];
    gpio_oe_i  = r[15:8];
    pad_in_i   = r[23:16];
    uart_tx_i  = r[24];
    spi_sck_i  = r[25];
  endtask

  // expected pad outputs from the model and the current inputs
  task automatic compare_pads(input string name);
    logic [NumPads-1:0] exp_out;
    logic [NumPads-1:0] exp_oe;
    logic [NumPads-1:0] exp_in;
    exp_out = '0;
    exp_oe  = '0;
    exp_in  = '0;
    for (int i = 0; i < NumPads; i++) begin
      case (sel_m[2*i +: 2])
        PAD_SEL_GPIO: begin
          exp_out[i] = gpio_out_i[i];
          exp_oe[i]  = gpio_oe_i[i];
          exp_in[i]  = pad_in_i[i];
        end
        PAD_SEL_UART_TX: begin
          exp_out[i] = uart_tx_i;
          exp_oe[i]  = 1'b1;
        end
        PAD_SEL_SPI_SCK: begin
          exp_out[i] = spi_sck_i;
          exp_oe[i]  = 1'b1;
        end
        default: ;
      endcase
    end
    exp_oe = exp_oe & ~mask_m;
    expect_eq({name, " pad_out"}, exp_out, pad_out_o);
    expect_eq({name, " pad_oe"}, exp_oe, pad_oe_o);
    expect_eq({name, " gpio_in"}, exp_in, gpio_in_o);
  endtask

  task automatic wait_ack(input logic level);
    int unsigned n;
    n = 0;
    while (cfg_ack_o !== level && n < AckTimeout) begin
      @(negedge ref_clk_i);
      n++;
    end
    assert (cfg_ack_o === level) else begin
      $display("handshake timeout: ack did not go to %0b within %0d cycles", level, AckTimeout);
      stop_on_failure();
    end
  endtask

  ////////////////////
  // four-phase source
  ////////////////////

  task automatic cfg_access(input logic [1:0] addr, input logic we, input logic [15:0] wdata,
                            output logic [15:0] rdata, output logic err);
    @(negedge ref_clk_i);
    cfg_addr_i  = addr;
    cfg_we_i    = we;
    cfg_wdata_i = wdata;
    @(negedge ref_clk_i);
    cfg_req_i = 1'b1;
    wait_ack(1'b1);
    rdata     = cfg_rdata_o;
    err       = cfg_err_o;
    cfg_req_i = 1'b0;
    wait_ack(1'b0);
  endtask

  task automatic write_reg(input logic [1:0] addr, input logic [15:0] data, input string name);
    logic [15:0] rd;
    logic        err;
    cfg_access(addr, 1'b1, data, rd, err);
    expect_eq({name, " err"}, addr > 1, err);
    if (addr == CfgAddrMuxSel) begin
      sel_m = data;
    end else if (addr == CfgAddrInMask) begin
      mask_m = data[7:0];
    end else begin
      expect_eq({name, " rdata"}, 0, rd);
    end
  endtask

  task automatic read_compare(input logic [1:0] addr, input string name);
    logic [15:0] rd;
    logic        err;
    logic [15:0] exp;
    exp = (addr == CfgAddrMuxSel) ? sel_m : (addr == CfgAddrInMask) ? {8'h00, mask_m} : 16'h0;
    cfg_access(addr, 1'b0, 16'h0, rd, err);
    expect_eq({name, " rdata"}, exp, rd);
    expect_eq({name, " err"}, addr > 1, err);
  endtask

  task automatic pad_routing(input logic use_mask, input string name);
    logic [31:0] r;
    repeat (NumRouteRounds) begin
      r = rand_word();
      write_reg(CfgAddrMuxSel, r[15:0], name);
      write_reg(CfgAddrInMask, use_mask ? {8'h00, r[23:16]} : 16'h0, name);
      drive_periph();
      // compare before each new drive
      repeat (RouteCycles) begin
        @(negedge ref_clk_i);
        compare_pads(name);
        drive_periph();
      end
    end
  endtask

  task automatic handshake_timing();
    logic [31:0] r;
    r = rand_word();
    @(negedge ref_clk_i);
    cfg_addr_i  = CfgAddrMuxSel;
    cfg_we_i    = 1'b1;
    cfg_wdata_i = r[15:0];
    @(negedge ref_clk_i);
    cfg_req_i = 1'b1;
    sel_m     = r[15:0];
    for (int k = 1; k <= 3; k++) begin
      @(negedge ref_clk_i);
      expect_eq("handshake ack rise", k == 3, cfg_ack_o);
    end
    compare_pads("handshake write");
    // new data while req stays high must not be written again
    cfg_wdata_i = ~r[15:0];
    repeat (20) begin
      @(negedge ref_clk_i);
      expect_eq("handshake ack hold", 1, cfg_ack_o);
      compare_pads("handshake hold");
    end
    cfg_req_i = 1'b0;
    for (int k = 1; k <= 3; k++) begin
      @(negedge ref_clk_i);
      expect_eq("handshake ack fall", k != 3, cfg_ack_o);
    end
    read_compare(CfgAddrMuxSel, "handshake readback");
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    logic [31:0] r;
    ref_clk_i   = 1'b0;
    rst_n_i     = 1'b0;
    cfg_req_i   = 1'b0;
    cfg_addr_i  = '0;
    cfg_we_i    = 1'b0;
    cfg_wdata_i = '0;
    gpio_out_i  = '0;
    gpio_oe_i   = '0;
    uart_tx_i   = 1'b0;
    spi_sck_i   = 1'b0;
    pad_in_i    = '0;
    rng_state   = 32'hff08_0017;
    sel_m       = 16'hffff;
    mask_m      = '0;
    repeat (2) @(posedge ref_clk_i);
    @(negedge ref_clk_i);
    rst_n_i = 1'b1;

    drive_periph();
    @(negedge ref_clk_i);
    expect_eq("reset pad_oe", 0, pad_oe_o);
    expect_eq("reset pad_out", 0, pad_out_o);
    expect_eq("reset gpio_in", 0, gpio_in_o);
    expect_eq("reset ack", 0, cfg_ack_o);

    repeat (NumRoundTrips) begin
      r = rand_word();
      write_reg({1'b0, r[0]}, r[31:16], "round trip write");
      read_compare({1'b0, r[0]}, "round trip read");
    end

    repeat (NumUnmapped) begin
      r = rand_word();
      if (r[1]) begin
        write_reg({1'b1, r[0]}, r[31:16], "unmapped write");
      end else begin
        read_compare({1'b1, r[0]}, "unmapped read");
      end
      read_compare(CfgAddrMuxSel, "unmapped sel check");
      read_compare(CfgAddrInMask, "unmapped mask check");
    end

    pad_routing(1'b0, "pad routing");
    pad_routing(1'b1, "input mask");
    handshake_timing();

    @(negedge ref_clk_i);
    if (dut.u_cfg_cdc.u_props.fail_count == 0) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      $display("handshake property failed in the config receiver");
      stop_on_failure();
    end
  end

  always @(negedge ref_clk_i) begin
    assert (dut.u_cfg_cdc.u_props.fail_count == 0) else begin
      $display("handshake property failed in the config receiver");
      stop_on_failure();
    end
  end

  initial begin
    #((NumTxn * 20 + MarginCycles) * ClkPeriod);
    $display("watchdog expired before the tests completed");
    stop_on_failure();
  end

endmodule

`default_nettype wire

// ==== padframe_top.f ====
padframe_pkg.sv
padframe_cfg_cdc.sv
padframe_cfg_regs.sv
padframe_pad_mux.sv
padframe_top.sv
padframe_props.sv
tb_padframe_top.sv

// ==== Bender.yml ====
package:
  name: padframe

sources:
  - padframe_pkg.sv
  - padframe_cfg_cdc.sv
  - padframe_cfg_regs.sv
  - padframe_pad_mux.sv
  - padframe_top.sv
  - target: test
    files:
      - padframe_props.sv
      - tb_padframe_top.sv
